// ==== hw/serpent_inv_config.svh ====
// sizing macros for the serpent decryption slice, included by the package and the top level
`ifndef SERPENT_INV_CONFIG_SVH
`define SERPENT_INV_CONFIG_SVH

// cipher block and round key width
`define SERPENT_BLOCK_W 128

// 4-bit s-box columns per block, also the word width of the bitslice
`define SERPENT_NIBBLES 32

// pipeline depth, equal to the block latency
`define SERPENT_STAGES 8

// round keys held, whitening key sits at the top index
`define SERPENT_KEYS 9

`endif

// ==== hw/serpent_inv_pkg.sv ====
// block, key and s-box table types shared by the decryption pipeline and its testbench
`include "serpent_inv_config.svh"

package serpent_inv_pkg;

	typedef logic [`SERPENT_BLOCK_W-1:0] block_t;
	typedef logic [`SERPENT_BLOCK_W-1:0] round_key_t;

	// valid addresses 0 to 8
	typedef logic [3:0] key_index_t;

	typedef logic [3:0] nibble_t;

	typedef round_key_t key_array_t [`SERPENT_KEYS];

	// standard serpent inverse s-boxes, indexed by box then input nibble
	localparam nibble_t sbox_inv_table [8][16] = '{
		// inv s0
		'{4'hd, 4'h3, 4'hb, 4'h0, 4'ha, 4'h6, 4'h5, 4'hc,
		  4'h1, 4'he, 4'h4, 4'h7, 4'hf, 4'h9, 4'h8, 4'h2},
		// inv s1
		'{4'h5, 4'h8, 4'h2, 4'he, 4'hf, 4'h6, 4'hc, 4'h3,
		  4'hb, 4'h4, 4'h7, 4'h9, 4'h1, 4'hd, 4'ha, 4'h0},
		// inv s2
		'{4'hc, 4'h9, 4'hf, 4'h4, 4'hb, 4'he, 4'h1, 4'h2,
		  4'h0, 4'h3, 4'h6, 4'hd, 4'h5, 4'h8, 4'ha, 4'h7},
		// inv s3
		'{4'h0, 4'h9, 4'ha, 4'h7, 4'hb, 4'he, 4'h6, 4'hd,
		  4'h3, 4'h5, 4'hc, 4'h2, 4'h4, 4'h8, 4'hf, 4'h1},
		// inv s4
		'{4'h5, 4'h0, 4'h8, 4'h3, 4'ha, 4'h9, 4'h7, 4'he,
		  4'h2, 4'hc, 4'hb, 4'h6, 4'h4, 4'hf, 4'hd, 4'h1},
		// inv s5
		'{4'h8, 4'hf, 4'h2, 4'h9, 4'h4, 4'h1, 4'hd, 4'he,
		  4'hb, 4'h6, 4'h5, 4'h3, 4'h7, 4'hc, 4'ha, 4'h0},
		// inv s6
		'{4'hf, 4'ha, 4'h1, 4'hd, 4'h5, 4'h3, 4'h6, 4'h0,
		  4'h4, 4'h9, 4'he, 4'h7, 4'h2, 4'hc, 4'h8, 4'hb},
		// inv s7
		'{4'h3, 4'h0, 4'h6, 4'hd, 4'h9, 4'he, 4'hf, 4'h8,
		  4'h5, 4'hc, 4'hb, 4'h7, 4'ha, 4'h1, 4'h4, 4'h2}
	};

endpackage

// ==== hw/sbox_inv_layer.sv ====
// combinational inverse s-box layer over a bitsliced block, one table chosen by parameter
`timescale 1ns/1ps
`include "serpent_inv_config.svh"

module sbox_inv_layer import serpent_inv_pkg::*; #(
	parameter int SBOX_INDEX = 7
) (
	input  block_t state_in,
	output block_t state_out
);

	// word width of the bitslice, one bit per column
	localparam int W = `SERPENT_NIBBLES;

	nibble_t col_in  [W];
	nibble_t col_out [W];

	for (genvar i = 0; i < W; i++)
	begin : gen_col
		// gather bit i of words 3..0 into one nibble, word 0 at the lsb
		assign col_in[i] = {
			state_in[3*W + i],
			state_in[2*W + i],
			state_in[W + i],
			state_in[i]
		};

		assign col_out[i] = sbox_inv_table[SBOX_INDEX][col_in[i]];

		// scatter back into the four words
		assign state_out[i]       = col_out[i][0];
		assign state_out[W + i]   = col_out[i][1];
		assign state_out[2*W + i] = col_out[i][2];
		assign state_out[3*W + i] = col_out[i][3];
	end

endmodule

// ==== hw/undo_final_round.sv ====
// first pipeline stage, undoes the last encryption round with two key mixes around s-box 7
`timescale 1ns/1ps

module undo_final_round import serpent_inv_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  block_t     in_block,
	input  round_key_t whitening_key,
	input  round_key_t round_key,
	output logic       valid,
	output block_t     block
);

	block_t whitened;
	block_t sbox_out;

	// strip the output whitening
	assign whitened = in_block ^ whitening_key;

	sbox_inv_layer #(
		.SBOX_INDEX(7)
	) sbox_inv_layer_inst (
		.state_in  (whitened),
		.state_out (sbox_out)
	);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid <= 1'b0;
		end
		else
		begin
			valid <= in_valid;
		end
	end

	// payload only moves with a valid block
	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			block <= sbox_out ^ round_key;
		end
	end

endmodule

// ==== hw/inv_round.sv ====
// one registered inverse serpent round: inverse linear transform, inverse s-box, key mix
`timescale 1ns/1ps

module inv_round import serpent_inv_pkg::*; #(
	parameter int SBOX_INDEX = 0
) (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  block_t     in_block,
	input  round_key_t round_key,
	output logic       valid,
	output block_t     block
);

	logic [31:0] x0;
	logic [31:0] x1;
	logic [31:0] x2;
	logic [31:0] x3;
	logic [31:0] t0;
	logic [31:0] t2;
	logic [31:0] y0;
	logic [31:0] y1;
	logic [31:0] y2;
	logic [31:0] y3;
	block_t      lt_out;
	block_t      sbox_out;

	assign {x3, x2, x1, x0} = in_block;

	// first half, undoes the last two steps of the forward transform
	assign t2 = {x2[21:0], x2[31:22]} ^ x3 ^ {x1[24:0], 7'h0};
	assign t0 = {x0[4:0], x0[31:5]} ^ x1 ^ x3;

	// second half
	assign y3 = {x3[6:0], x3[31:7]} ^ t2 ^ {t0[28:0], 3'h0};
	assign y1 = {x1[0], x1[31:1]} ^ t0 ^ t2;
	assign y2 = {t2[2:0], t2[31:3]};
	assign y0 = {t0[12:0], t0[31:13]};

	assign lt_out = {y3, y2, y1, y0};

	sbox_inv_layer #(
		.SBOX_INDEX(SBOX_INDEX)
	) sbox_inv_layer_inst (
		.state_in  (lt_out),
		.state_out (sbox_out)
	);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid <= 1'b0;
		end
		else
		begin
			valid <= in_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (in_valid)
		begin
			block <= sbox_out ^ round_key;
		end
	end

endmodule

// ==== hw/round_key_store.sv ====
// register file of the nine round keys, loaded one entry per write strobe
`timescale 1ns/1ps
`include "serpent_inv_config.svh"

module round_key_store import serpent_inv_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       key_we,
	input  key_index_t key_index,
	input  round_key_t key_data,
	output key_array_t keys
);

	logic [`SERPENT_KEYS-1:0] entry_we;

	// one-hot decode, out of range indices select nothing
	always_comb
	begin
		entry_we = '0;
		if (key_we && key_index < `SERPENT_KEYS)
		begin
			entry_we[key_index] = 1'b1;
		end
	end

	for (genvar i = 0; i < `SERPENT_KEYS; i++)
	begin : gen_entry
		always_ff @(posedge clk or negedge arst_n)
		begin
			if (!arst_n)
			begin
				keys[i] <= '0;
			end
			else if (entry_we[i])
			begin
				keys[i] <= key_data;
			end
		end
	end

endmodule

// ==== hw/serpent_inv_top.sv ====
// top of the eight-stage serpent decryption slice: key store, final-round undo, rounds 6..0
`timescale 1ns/1ps
`include "serpent_inv_config.svh"

module serpent_inv_top import serpent_inv_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       in_valid,
	input  block_t     in_block,
	input  logic       key_we,
	input  key_index_t key_index,
	input  round_key_t key_data,
	output logic       out_valid,
	output block_t     out_block
);

	key_array_t keys;

	// stage outputs indexed by s-box number, the feeder sits at the top entry
	logic   stage_valid [`SERPENT_STAGES];
	block_t stage_block [`SERPENT_STAGES];

	round_key_store round_key_store_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.key_we    (key_we),
		.key_index (key_index),
		.key_data  (key_data),
		.keys      (keys)
	);

	undo_final_round undo_final_round_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.in_block      (in_block),
		.whitening_key (keys[`SERPENT_KEYS-1]),
		.round_key     (keys[`SERPENT_KEYS-2]),
		.valid         (stage_valid[`SERPENT_STAGES-1]),
		.block         (stage_block[`SERPENT_STAGES-1])
	);

	// round i reads stage i+1 and drives stage i
	for (genvar i = 0; i < `SERPENT_STAGES - 1; i++)
	begin : gen_round
		inv_round #(
			.SBOX_INDEX(i)
		) inv_round_inst (
			.clk       (clk),
			.arst_n    (arst_n),
			.in_valid  (stage_valid[i+1]),
			.in_block  (stage_block[i+1]),
			.round_key (keys[i]),
			.valid     (stage_valid[i]),
			.block     (stage_block[i])
		);
	end

	assign out_valid = stage_valid[0];
	assign out_block = stage_block[0];

endmodule

// ==== sim/serpent_inv_props.sv ====
// bound checks on the decryption pipeline, attached to the top level by the testbench
`timescale 1ns/1ps
`include "serpent_inv_config.svh"

module serpent_inv_props import serpent_inv_pkg::*; (
	input logic       clk,
	input logic       arst_n,
	input logic       in_valid,
	input logic       key_we,
	input key_index_t key_index,
	input logic       out_valid,
	input key_array_t keys
);

	localparam int W = `SERPENT_BLOCK_W;

	// failed assertions, read by the testbench for its summary
	int assert_errors = 0;

	// clocks since reset release, saturating
	int unsigned cycles;

	logic [`SERPENT_KEYS*W-1:0] keys_flat;

	for (genvar i = 0; i < `SERPENT_KEYS; i++)
	begin : gen_flat
		assign keys_flat[i*W +: W] = keys[i];
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cycles <= 0;
		end
		else if (cycles < 1000)
		begin
			cycles <= cycles + 1;
		end
	end

	// output valid is the input valid delayed by the pipeline depth
	valid_delay: assert property (@(posedge clk) disable iff (!arst_n)
		(cycles >= `SERPENT_STAGES) |-> (out_valid == $past(in_valid, `SERPENT_STAGES)))
	else
	begin
		assert_errors++;
		$error("out_valid does not follow in_valid by the pipeline depth");
	end

	quiet_after_reset: assert property (@(posedge clk) disable iff (!arst_n)
		(cycles < `SERPENT_STAGES) |-> !out_valid)
	else
	begin
		assert_errors++;
		$error("out_valid high too soon after reset");
	end

	// out of range key writes must not touch the register file
	stray_write: assert property (@(posedge clk) disable iff (!arst_n)
		(key_we && key_index >= `SERPENT_KEYS) |=> $stable(keys_flat))
	else
	begin
		assert_errors++;
		$error("key write above the last index changed a stored key");
	end

endmodule

// ==== sim/serpent_inv_tb.sv ====
// self-checking testbench for the serpent decryption slice run from the tb.f file list
`timescale 1ns/1ps
`include "serpent_inv_config.svh"

module serpent_inv_tb import serpent_inv_pkg::*; ();

	localparam int NUM_ENTRIES = 40;
	localparam int W = `SERPENT_NIBBLES;

	logic       clk;
	logic       arst_n;
	logic       in_valid;
	block_t     in_block;
	logic       key_we;
	key_index_t key_index;
	round_key_t key_data;
	logic       out_valid;
	block_t     out_block;

	int seed = 32'hb5b4bbc8;

	// table columns are key set, block, gap, stray key write and expected result
	key_array_t tbl_keys   [NUM_ENTRIES];
	block_t     tbl_block  [NUM_ENTRIES];
	int         tbl_gap    [NUM_ENTRIES];
	bit         tbl_stray  [NUM_ENTRIES];
	block_t     tbl_expect [NUM_ENTRIES];

	key_array_t dut_keys;
	block_t     exp_q [$];
	logic [`SERPENT_STAGES-1:0] valid_hist = '0;

	int block_errors = 0;
	int valid_errors = 0;
	int other_errors = 0;
	int sent_count = 0;
	int recv_count = 0;
	int cycle_count = 0;
	int timeout_limit = 0;

	serpent_inv_top serpent_inv_top_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_block  (in_block),
		.key_we    (key_we),
		.key_index (key_index),
		.key_data  (key_data),
		.out_valid (out_valid),
		.out_block (out_block)
	);

	bind serpent_inv_top serpent_inv_props serpent_inv_props_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.key_we    (key_we),
		.key_index (key_index),
		.out_valid (out_valid),
		.keys      (keys)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] rotr(logic [31:0] x, int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// forward serpent linear mix undone step by step
	function automatic block_t inv_linear(block_t s);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		{d, c, b, a} = s;
		c = rotr(c, 22);
		a = rotr(a, 5);
		c = c ^ d ^ (b << 7);
		a = a ^ b ^ d;
		d = rotr(d, 7);
		b = rotr(b, 1);
		d = d ^ c ^ (a << 3);
		b = b ^ a ^ c;
		c = rotr(c, 3);
		a = rotr(a, 13);
		return {d, c, b, a};
	endfunction

	function automatic block_t sbox_columns(block_t s, int box);
		block_t  r;
		nibble_t n;
		nibble_t o;
		for (int i = 0; i < W; i++)
		begin
			n = {s[3*W + i], s[2*W + i], s[W + i], s[i]};
			o = sbox_inv_table[box][n];
			{r[3*W + i], r[2*W + i], r[W + i], r[i]} = o;
		end
		return r;
	endfunction

	function automatic block_t decrypt_block(block_t c, key_array_t k);
		block_t s;
		s = sbox_columns(c ^ k[8], 7) ^ k[7];
		for (int r = 6; r >= 0; r--)
		begin
			s = sbox_columns(inv_linear(s), r) ^ k[r];
		end
		return s;
	endfunction

	function automatic bit keys_differ(key_array_t a, key_array_t b);
		for (int i = 0; i < `SERPENT_KEYS; i++)
		begin
			if (a[i] !== b[i])
			begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	function block_t random_block();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic check_block(string name, block_t expected, block_t actual);
		if (actual !== expected)
		begin
			block_errors++;
			$display("FAILED time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		end
	endtask

	task automatic check_valid(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			valid_errors++;
			$display("FAILED time=%0t %s expected=%b actual=%b", $time, name, expected, actual);
		end
	endtask

	// sampled on the falling edge where outputs are settled
	always @(negedge clk)
	begin
		check_valid("out_valid", valid_hist[`SERPENT_STAGES-1], out_valid);
		valid_hist <= {valid_hist[`SERPENT_STAGES-2:0], in_valid};
		if (out_valid === 1'b1)
		begin
			recv_count++;
			if (exp_q.size() == 0)
			begin
				other_errors++;
				$display("out_valid high at %0t with no block outstanding", $time);
			end
			else
			begin
				check_block("out_block", exp_q.pop_front(), out_block);
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
	end

	initial
	begin
		@(posedge clk);
		while (cycle_count < timeout_limit)
		begin
			@(posedge clk);
		end
		$display("run timed out after %0d cycles waiting for outputs", cycle_count);
		$display("Test failures found");
		$finish;
	end

	task automatic write_key(key_index_t idx, round_key_t data);
		key_we = 1'b1;
		key_index = idx;
		key_data = data;
		@(posedge clk);
		#2;
		key_we = 1'b0;
	endtask

	task automatic drain();
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	// keys only change with the pipeline empty
	task automatic apply_keys(key_array_t want);
		if (keys_differ(want, dut_keys))
		begin
			drain();
			for (int i = 0; i < `SERPENT_KEYS; i++)
			begin
				if (want[i] !== dut_keys[i])
				begin
					write_key(key_index_t'(i), want[i]);
				end
			end
			dut_keys = want;
		end
	endtask

	task automatic send_block(block_t blk, block_t expected, int gap);
		in_valid = 1'b1;
		in_block = blk;
		exp_q.push_back(expected);
		sent_count++;
		@(posedge clk);
		#2;
		in_valid = 1'b0;
		repeat (gap)
		begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic build_table();
		key_array_t base;
		key_array_t set1;
		key_array_t set2;
		for (int i = 0; i < `SERPENT_KEYS; i++)
		begin
			base[i] = random_block();
		end
		set1 = base;
		set1[8] = random_block();
		set2 = set1;
		set2[3] = random_block();
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			tbl_block[i] = random_block();
			tbl_stray[i] = 1'b0;
			if (i < 4)
			begin
				tbl_keys[i] = base;
				tbl_gap[i] = 12;
			end
			else if (i < 20)
			begin
				tbl_keys[i] = base;
				tbl_gap[i] = 0;
			end
			else if (i < 32)
			begin
				tbl_keys[i] = base;
				tbl_gap[i] = int'($unsigned($random(seed)) % 4);
			end
			else if (i < 34)
			begin
				tbl_keys[i] = set1;
				tbl_gap[i] = 3;
			end
			else
			begin
				tbl_keys[i] = set2;
				tbl_gap[i] = 3;
			end
		end
		tbl_block[0] = '0;
		tbl_block[1] = '1;
		tbl_stray[36] = 1'b1;
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			tbl_expect[i] = decrypt_block(tbl_block[i], tbl_keys[i]);
		end
	endtask

	initial
	begin
		int total;
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_block = '0;
		key_we = 1'b0;
		key_index = '0;
		key_data = '0;
		for (int i = 0; i < `SERPENT_KEYS; i++)
		begin
			dut_keys[i] = '0;
		end
		build_table();

		// reset, idle, entries with key loads, then the final drain
		timeout_limit = 4 + `SERPENT_STAGES + 16 + 50;
		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			timeout_limit += 1 + tbl_gap[i];
			if (i == 0 || keys_differ(tbl_keys[i], tbl_keys[i-1]))
			begin
				timeout_limit += `SERPENT_KEYS + `SERPENT_STAGES + 2;
			end
			if (tbl_stray[i])
			begin
				timeout_limit += `SERPENT_STAGES + 2;
			end
		end

		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;
		repeat (`SERPENT_STAGES)
		begin
			@(posedge clk);
			#2;
		end

		for (int i = 0; i < NUM_ENTRIES; i++)
		begin
			apply_keys(tbl_keys[i]);
			if (tbl_stray[i])
			begin
				drain();
				write_key(4'd12, random_block());
			end
			send_block(tbl_block[i], tbl_expect[i], tbl_gap[i]);
		end
		drain();
		repeat (4) @(posedge clk);

		if (recv_count != sent_count)
		begin
			other_errors++;
			$display("sent %0d blocks but received %0d", sent_count, recv_count);
		end
		total = block_errors + valid_errors + other_errors +
			serpent_inv_top_inst.serpent_inv_props_inst.assert_errors;
		$display("errors: block %0d, valid %0d, other %0d, assertion %0d, total %0d",
			block_errors, valid_errors, other_errors,
			serpent_inv_top_inst.serpent_inv_props_inst.assert_errors, total);
		if (total == 0)
		begin
			$display("All tests passed!");
		end
		else
		begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+hw
hw/serpent_inv_pkg.sv
hw/sbox_inv_layer.sv
hw/undo_final_round.sv
hw/inv_round.sv
hw/round_key_store.sv
hw/serpent_inv_top.sv
sim/serpent_inv_props.sv
sim/serpent_inv_tb.sv

// ==== Bender.yml ====
package:
  name: serpent_inv

dependencies: {}

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/serpent_inv_pkg.sv
      - hw/sbox_inv_layer.sv
      - hw/undo_final_round.sv
      - hw/inv_round.sv
      - hw/round_key_store.sv
      - hw/serpent_inv_top.sv

  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/serpent_inv_props.sv
      - sim/serpent_inv_tb.sv
